//--- tb.f
+incdir+.
convPkg.sv
convIfs.sv
tileStore.sv
convSequencer.sv
macUnit.sv
resultFifo.sv
convLayer.sv
tb_convLayer.sv

//--- Makefile
# Verilator build and run for the convolution layer testbench

VERILATOR ?= verilator
TOP       ?= tb_convLayer
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep '\.sv$$' $(FILELIST)) conv_config.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_convLayer.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module tb_convLayer import convPkg::*; ();

    localparam int IMG_WORDS = `CONV_IMG_DIM * `CONV_IMG_DIM;
    localparam int K_WORDS = `CONV_K_DIM * `CONV_K_DIM;
    localparam int OUT_WORDS = `CONV_OUT_DIM * `CONV_OUT_DIM;
    localparam int ACK_TIMEOUT = 10;
    localparam int RUN_TIMEOUT = 20000;

    logic  clk = 1'b0;
    logic  resetn;
    logic  loadValid;
    logic  loadIsWeight;
    pixelT loadData;
    logic  start;
    logic  startAck;
    logic  busy;
    logic  outValid;
    accT   outData;
    logic  outReady;

    // working data, what the DUT memories should hold
    pixelT  img [IMG_WORDS];
    weightT kern [K_WORDS];
    weightT keptKern [K_WORDS];

    // outReady pattern for the back-pressure test
    bit         readyPat [256];
    logic [7:0] readyIdx = '0;
    logic       randReady = 1'b0;

    // expected results in order, popped by the monitor
    accT   expQ [$];
    int    rcvCount = 0;
    logic  stalled = 1'b0;
    accT   heldData;
    int    monErrors = 0;
    int    monChecks = 0;
    int    mainErrors = 0;
    int    mainChecks = 0;
    int    testsRun = 0;
    int    testsFailed = 0;
    int    testBase;
    string testName;
    logic  timedOut = 1'b0;

    always #50 clk = ~clk;

    convLayer dut_i (
        .clk          (clk),
        .resetn       (resetn),
        .loadValid    (loadValid),
        .loadIsWeight (loadIsWeight),
        .loadData     (loadData),
        .start        (start),
        .startAck     (startAck),
        .busy         (busy),
        .outValid     (outValid),
        .outData      (outData),
        .outReady     (outReady)
    );

    //////////////////////////////
    // reference model and checks
    //////////////////////////////

    // 49 products per tile, then bias, then ReLU
    function automatic void refConv(input pixelT im [IMG_WORDS], input weightT k [K_WORDS],
                                    output accT res [OUT_WORDS]);
        int sum;
        int row;
        int col;
        for (int tr = 0; tr < `CONV_OUT_DIM; tr++) begin
            for (int tc = 0; tc < `CONV_OUT_DIM; tc++) begin
                sum = 0;
                for (int kr = 0; kr < `CONV_K_DIM; kr++) begin
                    for (int kc = 0; kc < `CONV_K_DIM; kc++) begin
                        row = tr * `CONV_K_DIM + kr;
                        col = tc * `CONV_K_DIM + kc;
                        sum += int'(im[imgAddrT'(row * `CONV_IMG_DIM + col)])
                            * int'(k[wAddrT'(kr * `CONV_K_DIM + kc)]);
                    end
                end
                sum += `CONV_BIAS;
                res[4'(tr * `CONV_OUT_DIM + tc)] = (sum < 0) ? accT'(0) : accT'(sum);
            end
        end
    endfunction

    task automatic checkResult(input accT got, input accT exp, input string what);
        monChecks++;
        if (got !== exp) begin
            monErrors++;
            $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkCount(input int got, input int exp, input string what);
        mainChecks++;
        if (got != exp) begin
            mainErrors++;
            $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // sample on the rising edge, inputs move on the falling one
    always @(posedge clk) begin
        if (stalled && !outValid) begin
            monErrors++;
            $display("outValid dropped at %0t while the word was stalled", $time);
        end else if (stalled) begin
            checkResult(outData, heldData, "outData while stalled");
        end
        if (outValid && outReady) begin
            if (expQ.size() == 0) begin
                monErrors++;
                $display("extra result %0d arrived at %0t with none expected", outData, $time);
            end else begin
                checkResult(outData, expQ.pop_front(), $sformatf("result %0d", rcvCount));
            end
            rcvCount++;
        end
        stalled = outValid && !outReady;
        heldData = outData;
    end

    // next layer side, only this process drives outReady
    initial begin
        outReady = 1'b1;
        forever begin
            @(negedge clk);
            if (randReady) begin
                outReady = readyPat[readyIdx];
                readyIdx = readyIdx + 8'd1;
            end else begin
                outReady = 1'b1;
            end
        end
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    task automatic loadImage();
        for (int i = 0; i < IMG_WORDS; i++) begin
            loadValid = 1'b1;
            loadIsWeight = 1'b0;
            loadData = img[imgAddrT'(i)];
            @(negedge clk);
        end
        loadValid = 1'b0;
    endtask

    task automatic loadKernel();
        for (int i = 0; i < K_WORDS; i++) begin
            loadValid = 1'b1;
            loadIsWeight = 1'b1;
            loadData = pixelT'(kern[wAddrT'(i)]);
            @(negedge clk);
        end
        loadValid = 1'b0;
    endtask

    task automatic randomImage();
        for (int i = 0; i < IMG_WORDS; i++) begin
            img[imgAddrT'(i)] = pixelT'($urandom);
        end
    endtask

    task automatic expectFromRef();
        accT res [OUT_WORDS];
        refConv(img, kern, res);
        expQ.delete();
        for (int i = 0; i < OUT_WORDS; i++) begin
            expQ.push_back(res[4'(i)]);
        end
    endtask

    task automatic expectAll(input accT value);
        expQ.delete();
        for (int i = 0; i < OUT_WORDS; i++) begin
            expQ.push_back(value);
        end
    endtask

    // start handshake, then wait for 16 results and busy low
    task automatic runConv(input bit junkLoads);
        int cyc;
        int ackCycles;
        int base;
        base = rcvCount;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        cyc = 0;
        while (!startAck && cyc < ACK_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!startAck) begin
            $display("no startAck within %0d cycles of start", ACK_TIMEOUT);
            timedOut = 1'b1;
            return;
        end
        // ack belongs to the cycle right after start was taken
        checkCount(cyc, 0, "cycles from start to startAck");
        checkCount(int'(busy), 1, "busy while startAck is high");
        ackCycles = 0;
        while (startAck && ackCycles < ACK_TIMEOUT) begin
            ackCycles++;
            @(negedge clk);
        end
        checkCount(ackCycles, 1, "startAck length in cycles");
        cyc = 0;
        while ((rcvCount - base < OUT_WORDS || busy) && cyc < RUN_TIMEOUT) begin
            // words offered during a run must be dropped
            if (junkLoads && busy) begin
                loadValid = 1'b1;
                loadIsWeight = 1'($urandom);
                loadData = pixelT'($urandom);
            end else begin
                loadValid = 1'b0;
            end
            @(negedge clk);
            cyc++;
        end
        loadValid = 1'b0;
        if (busy || rcvCount - base < OUT_WORDS) begin
            $display("run not finished after %0d cycles, %0d results seen",
                     RUN_TIMEOUT, rcvCount - base);
            timedOut = 1'b1;
            return;
        end
        checkCount(rcvCount - base, OUT_WORDS, "results in this run");
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testBase = mainErrors + monErrors;
        testsRun++;
    endtask

    task automatic endTest();
        int errs;
        errs = mainErrors + monErrors - testBase;
        if (errs == 0 && !timedOut) begin
            $display("test %0d %s: ok", testsRun, testName);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed, %0d errors", testsRun, testName, errs);
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        void'($urandom(32'h78eaedd5));
        resetn = 1'b0;
        loadValid = 1'b0;
        loadIsWeight = 1'b0;
        loadData = '0;
        start = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        checkCount(int'(startAck), 0, "startAck after reset");
        checkCount(int'(busy), 0, "busy after reset");
        checkCount(int'(outValid), 0, "outValid after reset");

        // all ones, 49 minus the bias of 5
        beginTest("known values");
        for (int i = 0; i < IMG_WORDS; i++) begin
            img[imgAddrT'(i)] = 8'd1;
        end
        for (int i = 0; i < K_WORDS; i++) begin
            kern[wAddrT'(i)] = 8'sd1;
        end
        loadImage();
        loadKernel();
        expectAll(44);
        runConv(1'b0);
        endTest();

        if (!timedOut) begin
            beginTest("random data");
            randomImage();
            for (int i = 0; i < K_WORDS; i++) begin
                kern[wAddrT'(i)] = weightT'($urandom);
            end
            keptKern = kern;
            loadImage();
            loadKernel();
            expectFromRef();
            runConv(1'b0);
            endTest();
        end

        if (!timedOut) begin
            // weights from -1 down to -128, image kept from before
            beginTest("relu");
            for (int i = 0; i < K_WORDS; i++) begin
                kern[wAddrT'(i)] = weightT'(-1 - int'($urandom % 128));
            end
            loadKernel();
            expectAll(0);
            runConv(1'b0);
            endTest();
        end

        if (!timedOut) begin
            beginTest("back-pressure");
            kern = keptKern;
            loadKernel();
            // short burst of random ready, then a long stall so the queue fills up
            for (int i = 0; i < 256; i++) begin
                readyPat[i] = (i < 16) && ((i % 8 == 0) || 1'($urandom));
            end
            expectFromRef();
            randReady = 1'b1;
            runConv(1'b0);
            randReady = 1'b0;
            endTest();
        end

        if (!timedOut) begin
            // junk words during the first run, kernel reused by the second
            beginTest("loading rules");
            randomImage();
            loadImage();
            expectFromRef();
            runConv(1'b1);
            if (!timedOut) begin
                randomImage();
                loadImage();
                expectFromRef();
                runConv(1'b0);
            end
            endTest();
        end

        $display("tests run %0d, failed %0d, checks %0d, errors %0d", testsRun, testsFailed,
                 mainChecks + monChecks, mainErrors + monErrors);
        if (mainErrors + monErrors == 0 && !timedOut) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- convLayer.sv
`timescale 1ns/10ps
`default_nettype none

module convLayer import convPkg::*; (
    input  logic  clk,
    input  logic  resetn,
    // word stream into image and kernel memories
    input  logic  loadValid,
    input  logic  loadIsWeight,
    input  pixelT loadData,
    // start handshake
    input  logic  start,
    output logic  startAck,
    output logic  busy,
    // result stream to the next layer
    output logic  outValid,
    output accT   outData,
    input  logic  outReady
);

    logic tileDone;
    logic fifoFull;
    logic fifoEmpty;
    logic resultValid;
    accT  resultData;

    tapReqIf reqBus ();
    tapIf    tapBus ();

    //////////////////////////////
    // memories and tap walk
    //////////////////////////////

    tileStore store_i (
        .clk          (clk),
        .resetn       (resetn),
        .loadValid    (loadValid),
        .loadIsWeight (loadIsWeight),
        .loadData     (loadData),
        .busy         (busy),
        .startAck     (startAck),
        .req          (reqBus.receiver),
        .tap          (tapBus.sender)
    );

    convSequencer seq_i (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .startAck  (startAck),
        .busy      (busy),
        .tileDone  (tileDone),
        .fifoFull  (fifoFull),
        .fifoEmpty (fifoEmpty),
        .req       (reqBus.sender)
    );

    //////////////////////////////
    // arithmetic and output queue
    //////////////////////////////

    macUnit mac_i (
        .clk         (clk),
        .resetn      (resetn),
        .tap         (tapBus.receiver),
        .resultValid (resultValid),
        .resultData  (resultData),
        .tileDone    (tileDone)
    );

    resultFifo fifo_i (
        .clk         (clk),
        .resetn      (resetn),
        .resultValid (resultValid),
        .resultData  (resultData),
        .fifoFull    (fifoFull),
        .fifoEmpty   (fifoEmpty),
        .outValid    (outValid),
        .outData     (outData),
        .outReady    (outReady)
    );

endmodule

`default_nettype wire

//--- resultFifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module resultFifo import convPkg::*; (
    input  logic clk,
    input  logic resetn,
    input  logic resultValid,
    input  accT  resultData,
    output logic fifoFull,
    output logic fifoEmpty,
    output logic outValid,
    output accT  outData,
    input  logic outReady
);

    localparam int DEPTH = `CONV_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    accT mem [0:DEPTH-1];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic push;
    logic pop;

    // sequencer keeps room, so the push is never refused
    assign push = resultValid;
    assign pop = outValid && outReady;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= resultData;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // show-ahead, head word sits on outData while stalled
    assign outData = mem[rdPtr];
    assign outValid = (count != '0);
    assign fifoEmpty = (count == '0);
    assign fifoFull = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- macUnit.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module macUnit import convPkg::*; (
    input  logic      clk,
    input  logic      resetn,
    tapIf.receiver    tap,
    output logic      resultValid,
    output accT       resultData,
    output logic      tileDone
);

    // stage 1 registers
    logic prodValid;
    logic prodFirst;
    logic prodLast;
    accT  product;

    // stage 2 registers
    accT  accSum;
    logic doneQ;

    accT sum;
    accT biased;

    //////////////////////////////
    // stage 1, multiply
    //////////////////////////////

    // pixel gets a zero sign bit so the product is signed
    always_ff @(posedge clk) begin
        product <= $signed({1'b0, tap.pixel}) * tap.weight;
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            prodValid <= 1'b0;
            prodFirst <= 1'b0;
            prodLast <= 1'b0;
        end else begin
            prodValid <= tap.valid;
            prodFirst <= tap.first;
            prodLast <= tap.last;
        end
    end

    //////////////////////////////
    // stage 2, accumulate, bias, ReLU
    //////////////////////////////

    // first tap restarts the sum
    assign sum = (prodFirst ? accT'(0) : accSum) + product;
    assign biased = sum + accT'(`CONV_BIAS);

    always_ff @(posedge clk) begin
        if (prodValid) begin
            accSum <= sum;
        end
        if (prodValid && prodLast) begin
            // negative sums become zero
            resultData <= biased[`CONV_ACC_W-1] ? accT'(0) : biased;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            doneQ <= 1'b0;
        end else begin
            doneQ <= prodValid && prodLast;
        end
    end

    // one pulse per tile, to the queue and to the sequencer
    assign resultValid = doneQ;
    assign tileDone = doneQ;

endmodule

`default_nettype wire

//--- convSequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module convSequencer import convPkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  logic    start,
    output logic    startAck,
    output logic    busy,
    input  logic    tileDone,
    input  logic    fifoFull,
    input  logic    fifoEmpty,
    tapReqIf.sender req
);

    localparam int TILE_W = $clog2(`CONV_OUT_DIM);
    localparam int K_W = $clog2(`CONV_K_DIM);
    localparam int ROW_W = $clog2(`CONV_IMG_DIM);
    localparam int T_MAX = `CONV_OUT_DIM - 1;
    localparam int K_MAX = `CONV_K_DIM - 1;

    seqStateT state;
    seqStateT nextState;

    // tile position in the feature map
    logic [TILE_W-1:0] tileRow;
    logic [TILE_W-1:0] tileCol;
    // tap position inside the kernel
    logic [K_W-1:0] kRow;
    logic [K_W-1:0] kCol;
    // pixel row and column of the current tap
    logic [ROW_W-1:0] imgRow;
    logic [ROW_W-1:0] imgCol;

    logic lastTap;
    logic lastTile;
    // a tile has been issued and its result is not yet in the FIFO
    logic resultPending;

    assign lastTap = (kRow == K_W'(K_MAX)) && (kCol == K_W'(K_MAX));
    assign lastTile = (tileRow == TILE_W'(T_MAX)) && (tileCol == TILE_W'(T_MAX));

    //////////////////////////////
    // FSM
    //////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (start) begin
                    nextState = ACK;
                end
            end
            ACK: begin
                nextState = RUN;
            end
            RUN: begin
                if (lastTap) begin
                    nextState = FLUSH;
                end
            end
            FLUSH: begin
                // fifoFull is current once the pushed result has landed
                if (!resultPending) begin
                    if (lastTile) begin
                        nextState = DONEWAIT;
                    end else if (fifoFull) begin
                        nextState = WAITROOM;
                    end else begin
                        nextState = RUN;
                    end
                end
            end
            WAITROOM: begin
                if (!fifoFull) begin
                    nextState = RUN;
                end
            end
            DONEWAIT: begin
                // next layer drains the queue before we go idle
                if (fifoEmpty) begin
                    nextState = IDLE;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= IDLE;
            resultPending <= 1'b0;
            tileRow <= '0;
            tileCol <= '0;
            kRow <= '0;
            kCol <= '0;
        end else begin
            state <= nextState;
            if (state == RUN && lastTap) begin
                resultPending <= 1'b1;
            end else if (tileDone) begin
                resultPending <= 1'b0;
            end
            if (state == ACK) begin
                tileRow <= '0;
                tileCol <= '0;
                kRow <= '0;
                kCol <= '0;
            end else if (state == RUN) begin
                // kernel walk, row-major
                if (kCol == K_W'(K_MAX)) begin
                    kCol <= '0;
                    kRow <= lastTap ? '0 : kRow + 1'b1;
                end else begin
                    kCol <= kCol + 1'b1;
                end
            end else if (state == FLUSH && !resultPending) begin
                // tile walk, row-major, wraps after the last tile
                if (tileCol == TILE_W'(T_MAX)) begin
                    tileCol <= '0;
                    tileRow <= lastTile ? '0 : tileRow + 1'b1;
                end else begin
                    tileCol <= tileCol + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // outputs
    //////////////////////////////

    assign startAck = (state == ACK);
    assign busy = (state != IDLE);

    // stride equals kernel side so tiles do not overlap
    assign imgRow = ROW_W'(tileRow * `CONV_K_DIM + kRow);
    assign imgCol = ROW_W'(tileCol * `CONV_K_DIM + kCol);

    assign req.valid = (state == RUN);
    assign req.first = (state == RUN) && (kRow == '0) && (kCol == '0);
    assign req.last = (state == RUN) && lastTap;
    assign req.imgAddr = imgAddrT'(imgRow * `CONV_IMG_DIM + imgCol);
    assign req.wAddr = wAddrT'(kRow * `CONV_K_DIM + kCol);

endmodule

`default_nettype wire

//--- tileStore.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module tileStore import convPkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      loadValid,
    input  logic      loadIsWeight,
    input  pixelT     loadData,
    input  logic      busy,
    input  logic      startAck,
    tapReqIf.receiver req,
    tapIf.sender      tap
);

    localparam int IMG_WORDS = `CONV_IMG_DIM * `CONV_IMG_DIM;
    localparam int W_WORDS = `CONV_K_DIM * `CONV_K_DIM;

    // image in row-major order, kernel in row-major order
    pixelT  imgMem [0:IMG_WORDS-1];
    weightT wMem [0:W_WORDS-1];

    // next free word in each memory
    imgAddrT imgCnt;
    wAddrT   wCnt;
    logic    imgWr;
    logic    wWr;

    //////////////////////////////
    // load side
    //////////////////////////////

    // loading is closed while a run is going, extra words past the end are dropped
    assign imgWr = loadValid && !busy && !loadIsWeight && (imgCnt < imgAddrT'(IMG_WORDS));
    assign wWr = loadValid && !busy && loadIsWeight && (wCnt < wAddrT'(W_WORDS));

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            imgCnt <= '0;
            wCnt <= '0;
        end else if (startAck) begin
            // an accepted start rewinds both counters
            imgCnt <= '0;
            wCnt <= '0;
        end else begin
            if (imgWr) begin
                imgCnt <= imgCnt + 1'b1;
            end
            if (wWr) begin
                wCnt <= wCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imgWr) begin
            imgMem[imgCnt] <= loadData;
        end
        if (wWr) begin
            wMem[wCnt] <= weightT'(loadData);
        end
    end

    //////////////////////////////
    // tap read side
    //////////////////////////////

    // one cycle read of both memories
    always_ff @(posedge clk) begin
        tap.pixel <= imgMem[req.imgAddr];
        tap.weight <= wMem[req.wAddr];
    end

    // flags follow the data by the same cycle
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            tap.valid <= 1'b0;
            tap.first <= 1'b0;
            tap.last <= 1'b0;
        end else begin
            tap.valid <= req.valid;
            tap.first <= req.valid && req.first;
            tap.last <= req.valid && req.last;
        end
    end

endmodule

`default_nettype wire

//--- convIfs.sv
`timescale 1ns/10ps
`default_nettype none

//////////////////////////////
// tap request, sequencer to memories
//////////////////////////////

interface tapReqIf import convPkg::*; ();
    // one request per cycle while valid, no stall
    logic    valid;
    // first and last tap of a tile
    logic    first;
    logic    last;
    imgAddrT imgAddr;
    wAddrT   wAddr;

    modport sender (
        output valid, first, last, imgAddr, wAddr
    );

    modport receiver (
        input valid, first, last, imgAddr, wAddr
    );
endinterface

//////////////////////////////
// tap data, memories to MAC
//////////////////////////////

interface tapIf import convPkg::*; ();
    // flags are delayed to line up with the read data
    logic   valid;
    logic   first;
    logic   last;
    pixelT  pixel;
    weightT weight;

    modport sender (
        output valid, first, last, pixel, weight
    );

    modport receiver (
        input valid, first, last, pixel, weight
    );
endinterface

`default_nettype wire

//--- convPkg.sv
`default_nettype none

`include "conv_config.svh"

package convPkg;

    //////////////////////////////
    // data words
    //////////////////////////////

    // pixels are unsigned
    typedef logic [`CONV_PIX_W-1:0] pixelT;
    // weights carry a sign
    typedef logic signed [`CONV_W_W-1:0] weightT;
    // running sum and final result
    typedef logic signed [`CONV_ACC_W-1:0] accT;

    // 784 pixels need 10 address bits
    typedef logic [9:0] imgAddrT;
    // 49 weights need 6 address bits
    typedef logic [5:0] wAddrT;

    //////////////////////////////
    // controller
    //////////////////////////////

    // FSM states of the tile and tap walk
    typedef enum logic [2:0] {
        IDLE, ACK, RUN, FLUSH, WAITROOM, DONEWAIT
    } seqStateT;

endpackage

`default_nettype wire

//--- conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

//////////////////////////////
// image and kernel geometry
//////////////////////////////

// side of the square input image
`define CONV_IMG_DIM 28
// kernel side, the stride is the same
`define CONV_K_DIM 7
// side of the feature map
`define CONV_OUT_DIM 4

//////////////////////////////
// datapath widths
//////////////////////////////

`define CONV_PIX_W 8
`define CONV_W_W 8
`define CONV_ACC_W 32

// fixed bias added once per output
`define CONV_BIAS (-5)

// result queue entries
`define CONV_FIFO_DEPTH 4

`endif
